// ==== hdl/uart_pkg.sv ====
////////////////////////////////////////
// UART line definitions
// Bit timing and the byte type shared
// by the receiver and the transmitter
////////////////////////////////////////

package uart_pkg;

  ////////////////////////////////////////
  // Line timing

  // Clock cycles per bit period
  localparam int CLKS_PER_BIT = 16;

  // Counter width for one bit period
  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

  ////////////////////////////////////////
  // Types

  // One data byte on the line
  typedef logic [7:0] uart_byte_t;

  // Cycle count inside one bit period
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

endpackage

// ==== hdl/dbg_pkg.sv ====
////////////////////////////////////////
// Debug server definitions
// Protocol bytes, memory geometry and
// the APB request and response structs
////////////////////////////////////////

package dbg_pkg;

  ////////////////////////////////////////
  // Protocol bytes

  localparam uart_pkg::uart_byte_t CMD_READ  = 8'h11;
  localparam uart_pkg::uart_byte_t CMD_WRITE = 8'h12;
  localparam uart_pkg::uart_byte_t CODE_ACK  = 8'h06;
  localparam uart_pkg::uart_byte_t CODE_EOT  = 8'h04;

  // Address and length fields are 8 bytes each on the wire
  localparam int FIELD_BYTES = 8;

  ////////////////////////////////////////
  // Memory and transfer sizes

  localparam int MEM_DEPTH = 256;

  typedef logic [$clog2(MEM_DEPTH)-1:0]   mem_addr_t;
  typedef logic [15:0]                    xfer_len_t;
  typedef logic [$clog2(FIELD_BYTES)-1:0] field_idx_t;

  ////////////////////////////////////////
  // APB bus

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    mem_addr_t            paddr;
    uart_pkg::uart_byte_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                 pready;
    uart_pkg::uart_byte_t prdata;
  } apb_rsp_t;

endpackage

// ==== hdl/uart_rx.sv ====
////////////////////////////////////////
// UART receiver
// Samples 8N1 frames at bit midpoints
////////////////////////////////////////

module uart_rx (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 rx_i,
  output uart_pkg::uart_byte_t rx_byte_o,
  output logic                 rx_valid_o
);
  import uart_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_phase_e;

  rx_phase_e  phase_q;
  bit_cnt_t   cnt_q;
  logic [2:0] bit_idx_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  uart_byte_t shift_q;
  logic       mid_start;
  logic       bit_end;

  assign mid_start = (cnt_q == bit_cnt_t'(CLKS_PER_BIT / 2 - 1));
  assign bit_end   = (cnt_q == bit_cnt_t'(CLKS_PER_BIT - 1));
  assign rx_byte_o = shift_q;

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q    <= RX_IDLE;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      cnt_q      <= cnt_q + bit_cnt_t'(1);
      case (phase_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_sync_q) phase_q <= RX_START;
        end
        RX_START: begin
          // Re-align the counter to the bit midpoint
          if (mid_start) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            phase_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) phase_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          // Framing error drops the byte
          if (bit_end) begin
            rx_valid_o <= rx_sync_q;
            phase_q    <= RX_IDLE;
          end
        end
        default: phase_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (phase_q == RX_DATA && bit_end) shift_q <= {rx_sync_q, shift_q[7:1]};
  end

endmodule

// ==== hdl/uart_tx.sv ====
////////////////////////////////////////
// UART transmitter
// Sends 8N1 frames with a ready handshake
////////////////////////////////////////

module uart_tx (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  uart_pkg::uart_byte_t tx_byte_i,
  input  logic                 tx_valid_i,
  output logic                 tx_ready_o,
  output logic                 tx_o
);
  import uart_pkg::*;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_phase_e;

  tx_phase_e  phase_q;
  bit_cnt_t   cnt_q;
  logic [2:0] bit_idx_q;
  uart_byte_t shift_q;
  logic       bit_end;

  assign bit_end    = (cnt_q == bit_cnt_t'(CLKS_PER_BIT - 1));
  assign tx_ready_o = (phase_q == TX_IDLE);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_o      <= 1'b1;
    end else begin
      cnt_q <= bit_end ? '0 : cnt_q + bit_cnt_t'(1);
      case (phase_q)
        TX_IDLE: begin
          cnt_q <= '0;
          if (tx_valid_i) begin
            tx_o    <= 1'b0;
            phase_q <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            tx_o      <= shift_q[0];
            bit_idx_q <= '0;
            phase_q   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            tx_o      <= (bit_idx_q == 3'd7) ? 1'b1 : shift_q[0];
            if (bit_idx_q == 3'd7) phase_q <= TX_STOP;
          end
        end
        TX_STOP: begin
          if (bit_end) phase_q <= TX_IDLE;
        end
        default: phase_q <= TX_IDLE;
      endcase
    end
  end

  // Shift out LSB first, one bit per period
  always_ff @(posedge clk) begin
    if (tx_ready_o && tx_valid_i) begin
      shift_q <= tx_byte_i;
    end else if (bit_end && (phase_q == TX_START || phase_q == TX_DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

// ==== hdl/dbg_cmd_engine.sv ====
////////////////////////////////////////
// Debug command engine
// Decodes READ, WRITE and ACK challenges
// and moves bytes over APB
////////////////////////////////////////

module dbg_cmd_engine (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  uart_pkg::uart_byte_t rx_byte_i,
  input  logic                 rx_valid_i,
  output uart_pkg::uart_byte_t tx_byte_o,
  output logic                 tx_valid_o,
  input  logic                 tx_ready_i,
  output dbg_pkg::apb_req_t    apb_req_o,
  input  dbg_pkg::apb_rsp_t    apb_rsp_i
);
  import uart_pkg::*;
  import dbg_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE, ST_ADDR, ST_LEN, ST_ACK, ST_DATA, ST_APB, ST_EOT
  } state_e;

  state_e     state_q;
  field_idx_t field_idx_q;
  logic       is_write_q;
  logic       echo_q;
  logic       penable_q;
  mem_addr_t  addr_q;
  xfer_len_t  len_q;
  uart_byte_t data_q;
  logic       tx_fire;
  logic       apb_done;
  logic       beat_done;
  logic       last_beat;
  logic       field_last;

  assign tx_fire    = tx_valid_o & tx_ready_i;
  assign apb_done   = (state_q == ST_APB) & penable_q & apb_rsp_i.pready;
  assign field_last = (field_idx_q == field_idx_t'(FIELD_BYTES - 1));
  assign last_beat  = (len_q == xfer_len_t'(1));
  // A byte is finished once stored, or once handed to the transmitter
  assign beat_done  = is_write_q ? apb_done : (state_q == ST_DATA && tx_fire);

  assign tx_valid_o = (state_q == ST_ACK) || (state_q == ST_EOT) ||
                      (state_q == ST_DATA && !is_write_q);

  always_comb begin
    case (state_q)
      ST_ACK:  tx_byte_o = CODE_ACK;
      ST_EOT:  tx_byte_o = CODE_EOT;
      default: tx_byte_o = data_q;
    endcase
  end

  assign apb_req_o = '{
    psel:    (state_q == ST_APB),
    penable: penable_q,
    pwrite:  is_write_q,
    paddr:   addr_q,
    pwdata:  data_q
  };

  ////////////////////////////////////////
  // Protocol FSM

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ST_IDLE;
      field_idx_q <= '0;
      is_write_q  <= 1'b0;
      echo_q      <= 1'b0;
      penable_q   <= 1'b0;
      addr_q      <= '0;
      len_q       <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          field_idx_q <= '0;
          if (rx_valid_i) begin
            is_write_q <= (rx_byte_i == CMD_WRITE);
            echo_q     <= (rx_byte_i == CODE_ACK);
            // Unknown bytes are dropped silently
            if (rx_byte_i == CMD_READ || rx_byte_i == CMD_WRITE) state_q <= ST_ADDR;
            else if (rx_byte_i == CODE_ACK) state_q <= ST_ACK;
          end
        end
        ST_ADDR, ST_LEN: begin
          if (rx_valid_i) begin
            // Only the low bytes of each field are kept
            if (state_q == ST_ADDR && field_idx_q == '0) addr_q <= mem_addr_t'(rx_byte_i);
            if (state_q == ST_LEN && field_idx_q == '0) len_q[7:0] <= rx_byte_i;
            if (state_q == ST_LEN && field_idx_q == field_idx_t'(1)) len_q[15:8] <= rx_byte_i;
            field_idx_q <= field_idx_q + field_idx_t'(1);
            if (field_last) state_q <= (state_q == ST_ADDR) ? ST_LEN : ST_ACK;
          end
        end
        ST_ACK: begin
          if (tx_fire) begin
            if (echo_q) state_q <= ST_IDLE;
            else if (len_q == '0) state_q <= ST_EOT;
            else state_q <= is_write_q ? ST_DATA : ST_APB;
          end
        end
        ST_DATA: begin
          if (is_write_q && rx_valid_i) state_q <= ST_APB;
          if (!is_write_q && tx_fire) state_q <= last_beat ? ST_EOT : ST_APB;
        end
        ST_APB: begin
          if (!penable_q) begin
            penable_q <= 1'b1;
          end else if (apb_rsp_i.pready) begin
            penable_q <= 1'b0;
            if (is_write_q && last_beat) state_q <= ST_EOT;
            else state_q <= ST_DATA;
          end
        end
        ST_EOT: begin
          if (tx_fire) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
      // Address wraps at the memory size
      if (beat_done) begin
        addr_q <= addr_q + mem_addr_t'(1);
        len_q  <= len_q - xfer_len_t'(1);
      end
    end
  end

  // Byte in flight, from the line or from memory
  always_ff @(posedge clk) begin
    if (state_q == ST_DATA && is_write_q && rx_valid_i) data_q <= rx_byte_i;
    else if (apb_done && !is_write_q) data_q <= apb_rsp_i.prdata;
  end

endmodule

// ==== hdl/dbg_scratch_mem.sv ====
////////////////////////////////////////
// Scratch memory
// 256 bytes behind an APB completer
////////////////////////////////////////

module dbg_scratch_mem (
  input  logic              clk,
  input  logic              arst_n_i,
  input  dbg_pkg::apb_req_t apb_req_i,
  output dbg_pkg::apb_rsp_t apb_rsp_o
);
  import uart_pkg::*;
  import dbg_pkg::*;

  uart_byte_t mem_q [MEM_DEPTH];
  uart_byte_t rdata_q;
  logic       wait_q;
  logic       access;

  assign access = apb_req_i.psel & apb_req_i.penable;

  // Reads need one wait state for the registered port
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) wait_q <= 1'b0;
    else wait_q <= access & ~apb_req_i.pwrite & ~wait_q;
  end

  always_ff @(posedge clk) begin
    if (access && apb_req_i.pwrite) mem_q[apb_req_i.paddr] <= apb_req_i.pwdata;
    if (access && !apb_req_i.pwrite) rdata_q <= mem_q[apb_req_i.paddr];
  end

  assign apb_rsp_o.pready = access & (apb_req_i.pwrite | wait_q);
  assign apb_rsp_o.prdata = rdata_q;

endmodule

// ==== hdl/uart_dbg_top.sv ====
////////////////////////////////////////
// UART debug server top
// Receiver, command engine, scratch
// memory and transmitter
////////////////////////////////////////

module uart_dbg_top (
  input  logic clk,
  input  logic arst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);
  import uart_pkg::*;
  import dbg_pkg::*;

  uart_byte_t rx_byte;
  logic       rx_valid;
  uart_byte_t tx_byte;
  logic       tx_valid;
  logic       tx_ready;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;

  ////////////////////////////////////////
  // Input side

  uart_rx i_uart_rx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .rx_i       ( uart_rx_i ),
    .rx_byte_o  ( rx_byte   ),
    .rx_valid_o ( rx_valid  )
  );

  ////////////////////////////////////////
  // Processing

  dbg_cmd_engine i_dbg_cmd_engine (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n_i ),
    .rx_byte_i  ( rx_byte  ),
    .rx_valid_i ( rx_valid ),
    .tx_byte_o  ( tx_byte  ),
    .tx_valid_o ( tx_valid ),
    .tx_ready_i ( tx_ready ),
    .apb_req_o  ( apb_req  ),
    .apb_rsp_i  ( apb_rsp  )
  );

  dbg_scratch_mem i_dbg_scratch_mem (
    .clk       ( clk      ),
    .arst_n_i  ( arst_n_i ),
    .apb_req_i ( apb_req  ),
    .apb_rsp_o ( apb_rsp  )
  );

  ////////////////////////////////////////
  // Output side

  uart_tx i_uart_tx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_valid_i ( tx_valid  ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

endmodule

// ==== tests/uart_dbg_assertions.sv ====
////////////////////////////////////////
// Debug server protocol assertions
// APB handshake rules and the idle level
// of the transmit line
////////////////////////////////////////

module uart_dbg_assertions (
  input logic              clk,
  input logic              arst_n_i,
  input dbg_pkg::apb_req_t apb_req_i,
  input dbg_pkg::apb_rsp_t apb_rsp_i,
  input logic              tx_ready_i,
  input logic              uart_tx_i
);

  // Access phase only after a setup cycle
  penable_after_setup: assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(apb_req_i.penable) |-> $past(apb_req_i.psel) && !$past(apb_req_i.penable))
    else $error("APB penable rose without a setup cycle");

  penable_needs_psel: assert property (@(posedge clk) disable iff (!arst_n_i)
    apb_req_i.penable |-> apb_req_i.psel)
    else $error("APB penable high while psel is low");

  // Request held until the completer answers
  request_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    apb_req_i.psel && !(apb_req_i.penable && apb_rsp_i.pready) |=>
      $stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite) && $stable(apb_req_i.pwdata))
    else $error("APB request changed while the transfer was waiting");

  pready_in_access: assert property (@(posedge clk) disable iff (!arst_n_i)
    apb_rsp_i.pready |-> apb_req_i.psel && apb_req_i.penable)
    else $error("APB pready high outside an access cycle");

  // Idle transmitter keeps the line at mark level
  tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n_i)
    tx_ready_i |-> uart_tx_i)
    else $error("Transmit line low while the transmitter is idle");

endmodule

// ==== tests/tb_uart_dbg.sv ====
////////////////////////////////////////
// UART debug server testbench
// Drives serial commands into the DUT and
// checks replies against a memory model
////////////////////////////////////////

module tb_uart_dbg;

  localparam int BIT_CYCLES  = 16;
  localparam int HALF_BIT    = 8;
  localparam int FIELD_BYTES = 8;
  localparam int RX_TIMEOUT  = 4000;

  localparam logic [7:0] READ_CMD  = 8'h11;
  localparam logic [7:0] WRITE_CMD = 8'h12;
  localparam logic [7:0] ACK_CODE  = 8'h06;
  localparam logic [7:0] EOT_CODE  = 8'h04;

  logic        clk;
  logic        arst_n_i;
  logic        uart_rx_i;
  logic        uart_tx_o;
  logic [7:0]  model_mem [256];
  logic [7:0]  send_q [$];
  logic [7:0]  reply_q [$];
  logic [7:0]  expect_q [$];
  logic [31:0] lcg_state;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  uart_dbg_top UUT (
    .clk       ( clk       ),
    .arst_n_i  ( arst_n_i  ),
    .uart_rx_i ( uart_rx_i ),
    .uart_tx_o ( uart_tx_o )
  );

  bind uart_dbg_top uart_dbg_assertions i_uart_dbg_assertions (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .apb_req_i  ( apb_req   ),
    .apb_rsp_i  ( apb_rsp   ),
    .tx_ready_i ( tx_ready  ),
    .uart_tx_i  ( uart_tx_o )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    lcg_state = lcg_next(lcg_state);
    b = lcg_state[31:24];
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %02h, actual %02h", name, exp, act);
      err_cnt++;
    end
  endtask

  // 8N1 frame, called on a falling edge
  task automatic send_byte(input logic [7:0] b);
    int i;
    uart_rx_i = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      uart_rx_i = b[i];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    uart_rx_i = 1'b1;
    repeat (BIT_CYCLES) @(negedge clk);
  endtask

  task automatic recv_byte(output logic [7:0] b, output bit ok);
    int waited;
    int i;
    b = '0;
    ok = 1'b0;
    waited = 0;
    while (uart_tx_o !== 1'b0 && waited < RX_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (uart_tx_o !== 1'b0) begin
      $display("Timeout: no start bit on uart_tx_o within %0d cycles", RX_TIMEOUT);
      err_cnt++;
      return;
    end
    // Sample at bit midpoints
    repeat (HALF_BIT) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (BIT_CYCLES) @(negedge clk);
    if (uart_tx_o !== 1'b1) begin
      $display("Framing error: stop bit on uart_tx_o was low");
      err_cnt++;
      return;
    end
    ok = 1'b1;
  endtask

  task automatic expect_silence(input string name, input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
        $display("%s: the DUT sent a byte where no reply was expected", name);
        err_cnt++;
        return;
      end
    end
  endtask

  task automatic queue_header(input logic [7:0] cmd, input logic [63:0] addr,
                              input logic [63:0] len);
    int i;
    send_q.push_back(cmd);
    for (i = 0; i < FIELD_BYTES; i++) send_q.push_back(addr[8*i +: 8]);
    for (i = 0; i < FIELD_BYTES; i++) send_q.push_back(len[8*i +: 8]);
  endtask

  // Send the queued bytes while collecting the reply
  task automatic exchange(input int reply_len);
    logic [7:0] b;
    bit         ok;
    int         si;
    reply_q.delete();
    fork
      begin
        for (si = 0; si < send_q.size(); si++) send_byte(send_q[si]);
      end
      begin
        ok = 1'b1;
        while (ok && reply_q.size() < reply_len) begin
          recv_byte(b, ok);
          if (ok) reply_q.push_back(b);
        end
      end
    join
    send_q.delete();
  endtask

  task automatic check_reply(input string name);
    int i;
    if (reply_q.size() != expect_q.size()) begin
      $display("[FAIL] %s: expected %0d reply bytes, actual %0d", name,
               expect_q.size(), reply_q.size());
      err_cnt++;
    end else begin
      for (i = 0; i < expect_q.size(); i++) check_value(name, expect_q[i], reply_q[i]);
    end
  endtask

  task automatic write_and_check(input string name, input logic [63:0] addr, input int len);
    logic [7:0] a;
    logic [7:0] b;
    int         i;
    queue_header(WRITE_CMD, addr, 64'(len));
    for (i = 0; i < len; i++) begin
      next_rand_byte(b);
      send_q.push_back(b);
      // Memory address wraps at 256
      a = addr[7:0] + i[7:0];
      model_mem[a] = b;
    end
    expect_q.delete();
    expect_q.push_back(ACK_CODE);
    expect_q.push_back(EOT_CODE);
    exchange(2);
    check_reply(name);
  endtask

  task automatic read_and_check(input string name, input logic [63:0] addr, input int len);
    logic [7:0] a;
    int         i;
    queue_header(READ_CMD, addr, 64'(len));
    expect_q.delete();
    expect_q.push_back(ACK_CODE);
    for (i = 0; i < len; i++) begin
      a = addr[7:0] + i[7:0];
      expect_q.push_back(model_mem[a]);
    end
    expect_q.push_back(EOT_CODE);
    exchange(expect_q.size());
    check_reply(name);
  endtask

  task automatic ack_and_check(input string name);
    send_q.push_back(ACK_CODE);
    expect_q.delete();
    expect_q.push_back(ACK_CODE);
    exchange(1);
    check_reply(name);
  endtask

  task automatic finish_test(input string name, input int err0);
    if (err_cnt == err0) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("Test %s finished with %0d errors", name, err_cnt - err0);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests

  task automatic test_ack_challenge();
    int err0;
    err0 = err_cnt;
    check_value("ack_challenge", 8'h01, {7'b0, uart_tx_o});
    ack_and_check("ack_challenge");
    // Exactly one byte back
    expect_silence("ack_challenge", 20 * BIT_CYCLES);
    finish_test("ack_challenge", err0);
  endtask

  task automatic test_write_read();
    int err0;
    err0 = err_cnt;
    write_and_check("write_read", 64'h20, 8);
    read_and_check("write_read", 64'h20, 8);
    finish_test("write_read", err0);
  endtask

  task automatic test_zero_length();
    int err0;
    err0 = err_cnt;
    read_and_check("zero_length", 64'h40, 0);
    finish_test("zero_length", err0);
  endtask

  task automatic test_addr_wrap();
    int err0;
    err0 = err_cnt;
    write_and_check("addr_wrap", 64'h1FE, 4);
    read_and_check("addr_wrap", 64'hFE, 2);
    read_and_check("addr_wrap", 64'h00, 2);
    finish_test("addr_wrap", err0);
  endtask

  task automatic test_unknown_byte();
    int err0;
    err0 = err_cnt;
    send_q.push_back(8'h55);
    exchange(0);
    expect_silence("unknown_byte", 30 * BIT_CYCLES);
    ack_and_check("unknown_byte");
    finish_test("unknown_byte", err0);
  endtask

  initial begin
    arst_n_i  = 1'b0;
    uart_rx_i = 1'b1;
    lcg_state = 32'd52;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    repeat (10) @(negedge clk);
    arst_n_i = 1'b1;
    repeat (4) @(negedge clk);

    test_ack_challenge();
    test_write_read();
    test_zero_length();
    test_addr_wrap();
    test_unknown_byte();

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
hdl/uart_pkg.sv
hdl/dbg_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/dbg_cmd_engine.sv
hdl/dbg_scratch_mem.sv
hdl/uart_dbg_top.sv
tests/uart_dbg_assertions.sv
tests/tb_uart_dbg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UART debug server testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_uart_dbg \
  --Mdir obj_dir -o tb_uart_dbg

./obj_dir/tb_uart_dbg | tee sim.log || true

if grep -qx "Simulation passed" sim.log; then
  echo "Result: PASS"
else
  echo "Result: FAIL"
  exit 1
fi
